// ==== flist.f ====
hw/uartLinePkg.sv
hw/periphBusPkg.sv
hw/baudTickGen.sv
hw/uartFifo.sv
hw/uartTrans.sv
hw/uartRecv.sv
hw/uartPeriph.sv
tb/uartPeriphTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the UART peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f flist.f --top-module uartPeriphTb -o simTb
./obj_dir/simTb | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== tb/uartPeriphTb.sv ====
`timescale 1ns/1ps
/*
	UART peripheral testbench
	drives the core strobes, loops tx back to rx or holds rx idle,
	decodes tx with its own line monitor and checks with assertions
*/
module uartPeriphTb;
	localparam int BAUD_DIV = 4;
	localparam int BIT_CYC = 64;			// 16 ticks of 4 clk
	localparam int FRAME_CYC = 10 * BIT_CYC;	// start + 8 data + stop
	localparam int TOTAL_FRAMES = 38;		// 1 + 3 + 17 + 17
	localparam int WATCHDOG_CYC = TOTAL_FRAMES * FRAME_CYC + 4000;

	logic clk = 1'b0;
	logic reset;
	periphBusPkg::coreReq_t req;
	periphBusPkg::uartStatus_t status;
	logic [7:0] rdData;
	logic tx, rxDrive, loopback, rxLine;
	logic [7:0] txRef[$];		// bytes still expected on tx
	logic [7:0] rxRef[$];		// bytes expected back at rdData
	int seed = 25589;
	int failCount = 0;
	int framesSeen = 0;		// frames decoded by the monitor
	int testsPassed = 0;
	int testsFailed = 0;
	int testStartFails;

	assign rxLine = loopback ? tx : rxDrive;	// loopback switch

	uartPeriph #(.DATA_BITS(8), .BAUD_DIV(BAUD_DIV), .FIFO_ADDR_BITS(4)) dut0 (
		.clk, .reset, .req, .rx(rxLine), .rdData, .status, .tx);

	always #4 clk = ~clk;	// 8 ns period

	task automatic reportMismatch(input string name, input logic [7:0] got,
		input logic [7:0] want);
		failCount++;
		$display("CHECK FAILED %s got 0x%02h expected 0x%02h at %0t", name, got, want, $time);
	endtask

	task automatic reportProblem(input string what);
		failCount++;
		$display("ERROR %s at %0t", what, $time);
	endtask

	//////////////////////
	// concurrent checks
	//////////////////////
	assert property (@(posedge clk) reset |=> (tx && status.txEmpty && status.rxEmpty &&
		!status.txFull && !status.rxFull && !status.overrun))
		else reportProblem("outputs not at their reset values during reset");

	// overrun only from a word arriving at a full rx FIFO
	assert property (@(posedge clk) disable iff (reset)
		$rose(status.overrun) |-> $past(status.rxFull))
		else reportProblem("overrun set while the rx FIFO was not full");

	//////////////////////
	// line monitor
	//////////////////////
	initial
	begin : lineMonitor
		logic [7:0] got, want;
		logic startLow, stopHigh;
		forever
		begin
			@(negedge tx);	// start bit edge
			repeat (BIT_CYC / 2) @(negedge clk);
			startLow = !tx;
			for (int i = 0; i < 8; i++)
			begin
				repeat (BIT_CYC) @(negedge clk);
				got[i] = tx;	// LSB first
			end
			repeat (BIT_CYC) @(negedge clk);
			stopHigh = tx;
			assert (startLow) else reportProblem("start bit not low at mid-bit");
			assert (stopHigh) else reportProblem("stop bit not high at mid-bit");
			if (txRef.size() == 0)
				reportProblem("frame on tx with no byte written");
			else
			begin
				want = txRef.pop_front();	// write order
				assert (got == want) else reportMismatch("tx frame data", got, want);
			end
			framesSeen++;
		end
	end

	function automatic logic [7:0] nextRandomByte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// called on a falling edge with a one-cycle strobe
	task automatic writeByte(input logic [7:0] b, output logic accepted);
		accepted = !status.txFull;	// full now means dropped at the next edge
		req.wr = 1'b1;
		req.wrData = b;
		if (accepted)
		begin
			txRef.push_back(b);
			if (loopback)
				rxRef.push_back(b);
		end
		@(negedge clk);
		req.wr = 1'b0;
		@(negedge clk);
	endtask

	task automatic readByte(input logic [7:0] want);
		int n;
		for (n = 0; n < 2 * FRAME_CYC && status.rxEmpty; n++)
			@(negedge clk);
		assert (!status.rxEmpty) else reportProblem("timed out waiting for a received byte");
		assert (rdData == want) else reportMismatch("rdData", rdData, want);
		req.rd = 1'b1;	// pop head
		@(negedge clk);
		req.rd = 1'b0;
	endtask

	task automatic waitFrames(input int target, input int limit);
		int n;
		for (n = 0; n < limit && framesSeen < target; n++)
			@(negedge clk);
		assert (framesSeen >= target) else reportProblem("timed out waiting for frames on tx");
	endtask

	task automatic finishTest(input string name);
		if (failCount == testStartFails)
		begin
			testsPassed++;
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d checks failed", name, failCount - testStartFails);
		end
		testStartFails = failCount;
	endtask

	//////////////////////
	// stimulus
	//////////////////////
	initial
	begin : stimulus
		logic ok;
		int n;
		reset = 1'b1;
		req = '0;
		rxDrive = 1'b1;		// idle line
		loopback = 1'b0;
		testStartFails = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// quiet line after reset
		assert (tx && status.txEmpty && status.rxEmpty && !status.overrun)
			else reportProblem("wrong state right after reset");
		for (n = 0; n < FRAME_CYC + BIT_CYC; n++)
		begin
			@(negedge clk);
			assert (tx) else reportProblem("tx left idle with no write");
		end
		assert (framesSeen == 0) else reportProblem("monitor saw a frame with no write");
		finishTest("reset state");

		writeByte(nextRandomByte(), ok);	// one frame with loopback off
		assert (ok) else reportProblem("write dropped with the tx FIFO empty");
		waitFrames(1, 2 * FRAME_CYC);
		finishTest("frame shape");

		loopback = 1'b1;
		for (n = 0; n < 3; n++)
			writeByte(nextRandomByte(), ok);
		while (rxRef.size() > 0)
			readByte(rxRef.pop_front());
		waitFrames(4, FRAME_CYC);
		repeat (BIT_CYC) @(negedge clk);	// transmitter back to idle
		assert (status.rxEmpty && status.txEmpty) else reportProblem("FIFOs not empty");
		finishTest("loopback receive");

		// one byte leaves for the shift register at once so 17 fit
		loopback = 1'b0;
		for (n = 1; n <= 18; n++)
		begin
			writeByte(nextRandomByte(), ok);
			assert (ok == (n <= 17)) else reportProblem("write acceptance wrong for tx space");
		end
		assert (status.txFull) else reportProblem("txFull not set after the burst");
		waitFrames(21, 18 * FRAME_CYC);
		assert (status.txEmpty && txRef.size() == 0)
			else reportProblem("tx FIFO not drained after the burst");
		repeat (BIT_CYC) @(negedge clk);
		finishTest("transmit queue");

		loopback = 1'b1;
		for (n = 0; n < 17; n++)
		begin
			writeByte(nextRandomByte(), ok);
			assert (ok) else reportProblem("write dropped while filling the loopback");
		end
		for (n = 0; n < 18 * FRAME_CYC && !status.overrun; n++)
			@(negedge clk);
		assert (status.overrun) else reportProblem("overrun never set");
		assert (status.rxFull) else reportProblem("rx FIFO not full at overrun");
		waitFrames(TOTAL_FRAMES, FRAME_CYC);
		req.statRd = 1'b1;	// one status read
		@(negedge clk);
		req.statRd = 1'b0;
		assert (!status.overrun) else reportProblem("status read did not clear overrun");
		for (n = 0; n < 16; n++)
			readByte(rxRef.pop_front());
		assert (status.rxEmpty) else reportProblem("rx FIFO held more than 16 bytes");
		rxRef.delete();		// 17th was lost
		finishTest("overrun");

		$display("tests ok %0d, tests with errors %0d, failed checks %0d",
			testsPassed, testsFailed, failCount);
		if (failCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== hw/uartPeriph.sv ====
`timescale 1ns/1ps
/*
	UART peripheral top
	core strobes feed the tx FIFO and drain the rx FIFO
	also holds the rx synchroniser, the overrun flag and the status word
*/
module uartPeriph #(
	parameter int DATA_BITS = uartLinePkg::DATA_BITS_DEF,
	parameter int SB_TICK = uartLinePkg::SB_TICK_DEF,
	parameter int BAUD_DIV = 27,		// clk cycles per 16x tick
	parameter int FIFO_ADDR_BITS = 4	// 16 entries
) (
	input logic clk,
	input logic reset,
	input periphBusPkg::coreReq_t req,
	input logic rx,
	output logic [periphBusPkg::BYTE_W-1:0] rdData,
	output periphBusPkg::uartStatus_t status,
	output logic tx
);
	logic sTick;
	logic [1:0] rxSync;		// two-flop synchroniser
	logic txFull, txEmpty, rxFull, rxEmpty;
	logic txPop;			// frame start
	logic rxDone;			// word received
	logic [DATA_BITS-1:0] txHead, rxWord, rxHead;
	logic overrun;

	baudTickGen #(.BAUD_DIV(BAUD_DIV)) tickGen (.clk, .reset, .sTick);

	//////////////////////
	// transmit path
	//////////////////////
	uartFifo #(.WIDTH(DATA_BITS), .ADDR_BITS(FIFO_ADDR_BITS)) txFifo (
		.clk, .reset,
		.push(req.wr),		// dropped when full
		.pop(txPop),
		.wrData(req.wrData[DATA_BITS-1:0]),
		.rdData(txHead), .full(txFull), .empty(txEmpty)
	);

	uartTrans #(.DATA_BITS(DATA_BITS), .SB_TICK(SB_TICK)) trans (
		.clk, .reset, .sTick,
		.txStart(!txEmpty), .din(txHead),
		.tx, .txDoneTick(txPop)
	);

	//////////////////////
	// receive path
	//////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rxSync <= 2'b11;	// idle line level
		else
			rxSync <= {rxSync[0], rx};
	end

	uartRecv #(.DATA_BITS(DATA_BITS), .SB_TICK(SB_TICK)) recv (
		.clk, .reset, .sTick,
		.rx(rxSync[1]), .dout(rxWord), .rxDoneTick(rxDone)
	);

	uartFifo #(.WIDTH(DATA_BITS), .ADDR_BITS(FIFO_ADDR_BITS)) rxFifo (
		.clk, .reset,
		.push(rxDone), .pop(req.rd),	// read on empty is ignored
		.wrData(rxWord),
		.rdData(rxHead), .full(rxFull), .empty(rxEmpty)
	);

	// word lost on a full rx FIFO, a new loss wins over the clearing read
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (rxDone && rxFull)
			overrun <= 1'b1;
		else if (req.statRd)
			overrun <= 1'b0;
	end

	assign rdData = periphBusPkg::BYTE_W'(rxHead);	// head of rx FIFO

	assign status.txFull = txFull;
	assign status.txEmpty = txEmpty;
	assign status.rxFull = rxFull;
	assign status.rxEmpty = rxEmpty;
	assign status.overrun = overrun;

endmodule

// ==== hw/uartRecv.sv ====
`timescale 1ns/1ps
/*
	UART receiver
	finds the start bit, samples each data bit at mid-bit on the 16x tick
	and strobes rxDoneTick with the word on dout after the stop period
*/
module uartRecv #(
	parameter int DATA_BITS = uartLinePkg::DATA_BITS_DEF,
	parameter int SB_TICK = uartLinePkg::SB_TICK_DEF
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,		// already synchronised
	output logic [DATA_BITS-1:0] dout,
	output logic rxDoneTick
);
	localparam int TICK_MAX = (uartLinePkg::OVERSAMPLE > SB_TICK) ?
		uartLinePkg::OVERSAMPLE : SB_TICK;
	localparam int S_W = $clog2(TICK_MAX);
	localparam int N_W = $clog2(DATA_BITS + 1);
	localparam logic [S_W-1:0] MID_BIT = S_W'(uartLinePkg::OVERSAMPLE / 2 - 1);
	localparam logic [S_W-1:0] BIT_END = S_W'(uartLinePkg::OVERSAMPLE - 1);
	localparam logic [S_W-1:0] STOP_END = S_W'(SB_TICK - 1);
	localparam logic [N_W-1:0] LAST_BIT = N_W'(DATA_BITS - 1);

	uartLinePkg::txState_t stateReg, stateNext;
	logic [S_W-1:0] sReg, sNext;	// ticks since last sample point
	logic [N_W-1:0] nReg, nNext;	// bits received so far
	logic [DATA_BITS-1:0] bReg, bNext;	// assembled word

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartLinePkg::IDLE;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////
	// next state
	//////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			uartLinePkg::IDLE:
			begin
				if (!rx)	// falling edge of a possible start bit
				begin
					sNext = '0;
					stateNext = uartLinePkg::START;
				end
			end
			uartLinePkg::START:
			begin
				if (sTick)
				begin
					if (sReg == MID_BIT)
					begin
						if (!rx)	// still low at mid start bit
						begin
							sNext = '0;
							nNext = '0;
							stateNext = uartLinePkg::DATA;
						end
						else
							stateNext = uartLinePkg::IDLE;	// glitch, drop it
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartLinePkg::DATA:
			begin
				if (sTick)
				begin
					if (sReg == BIT_END)	// mid of the next bit
					begin
						sNext = '0;
						bNext = {rx, bReg[DATA_BITS-1:1]};	// shift in from the top
						if (nReg == LAST_BIT)
							stateNext = uartLinePkg::STOP;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartLinePkg::STOP:
			begin
				// stop bit level is not checked
				if (sTick)
				begin
					if (sReg == STOP_END)
					begin
						rxDoneTick = 1'b1;
						stateNext = uartLinePkg::IDLE;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign dout = bReg;

endmodule

// ==== hw/uartTrans.sv ====
`timescale 1ns/1ps
/*
	UART transmitter
	sends one 8N1 frame per word, LSB first, paced by the 16x tick
	txDoneTick pops the tx FIFO as the frame leaves idle
*/
module uartTrans #(
	parameter int DATA_BITS = uartLinePkg::DATA_BITS_DEF,
	parameter int SB_TICK = uartLinePkg::SB_TICK_DEF
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txStart,	// tx FIFO not empty
	input logic [DATA_BITS-1:0] din,
	output logic tx,
	output logic txDoneTick
);
	localparam int TICK_MAX = (uartLinePkg::OVERSAMPLE > SB_TICK) ?
		uartLinePkg::OVERSAMPLE : SB_TICK;
	localparam int S_W = $clog2(TICK_MAX);
	localparam int N_W = $clog2(DATA_BITS + 1);
	localparam logic [S_W-1:0] BIT_END = S_W'(uartLinePkg::OVERSAMPLE - 1);
	localparam logic [S_W-1:0] STOP_END = S_W'(SB_TICK - 1);
	localparam logic [N_W-1:0] LAST_BIT = N_W'(DATA_BITS - 1);

	uartLinePkg::txState_t stateReg, stateNext;
	logic [S_W-1:0] sReg, sNext;	// tick counter within a bit
	logic [N_W-1:0] nReg, nNext;	// data bit index
	logic [DATA_BITS-1:0] bReg, bNext;	// shift register
	logic txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartLinePkg::IDLE;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;	// tx lags the state by one clk
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////
	// next state
	//////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			uartLinePkg::IDLE:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// pops FIFO this edge
					bNext = din;		// grab head before it advances
					sNext = '0;
					stateNext = uartLinePkg::START;
				end
			end
			uartLinePkg::START:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == BIT_END)
					begin
						sNext = '0;
						nNext = '0;
						stateNext = uartLinePkg::DATA;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartLinePkg::DATA:
			begin
				txNext = bReg[0];	// LSB first
				if (sTick)
				begin
					if (sReg == BIT_END)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == LAST_BIT)
							stateNext = uartLinePkg::STOP;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartLinePkg::STOP:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == STOP_END)
						stateNext = uartLinePkg::IDLE;	// next frame may start right away
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign tx = txReg;

endmodule

// ==== hw/uartFifo.sv ====
`timescale 1ns/1ps
/*
	first-word-fall-through FIFO
	head word sits on rdData while not empty, flags are registered
	push on full and pop on empty are ignored
*/
module uartFifo #(
	parameter int WIDTH = 8,
	parameter int ADDR_BITS = 4		// depth is 2**ADDR_BITS
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [WIDTH-1:0] wrData,
	output logic [WIDTH-1:0] rdData,
	output logic full,
	output logic empty
);
	localparam int DEPTH = 2 ** ADDR_BITS;

	logic [WIDTH-1:0] mem [DEPTH];	// storage, no reset
	logic [ADDR_BITS:0] wrPtr, rdPtr;	// extra msb tells full from empty
	logic [ADDR_BITS:0] wrNext, rdNext;
	logic doPush, doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign wrNext = wrPtr + {{ADDR_BITS{1'b0}}, doPush};
	assign rdNext = rdPtr + {{ADDR_BITS{1'b0}}, doPop};

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[ADDR_BITS-1:0]] <= wrData;
	end

	//////////////////////
	// pointers and flags
	//////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			wrPtr <= wrNext;
			rdPtr <= rdNext;
			empty <= (wrNext == rdNext);
			full <= (wrNext[ADDR_BITS-1:0] == rdNext[ADDR_BITS-1:0]) &&
				(wrNext[ADDR_BITS] != rdNext[ADDR_BITS]);	// wrapped once
		end
	end

	assign rdData = mem[rdPtr[ADDR_BITS-1:0]];	// head, valid when !empty

endmodule

// ==== hw/baudTickGen.sv ====
`timescale 1ns/1ps
/*
	baud tick generator
	divides clk down to the 16x oversampling tick for both serial engines
*/
module baudTickGen #(
	parameter int BAUD_DIV = 27		// clk cycles per tick
) (
	input logic clk,
	input logic reset,
	output logic sTick
);
	localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(BAUD_DIV - 1);

	logic [CNT_W-1:0] cnt;	// counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= RELOAD;	// first tick BAUD_DIV-1 cycles after reset
		else if (cnt == '0)
			cnt <= RELOAD;
		else
			cnt <= cnt - 1'b1;
	end

	assign sTick = (cnt == '0);	// one cycle wide

endmodule

// ==== hw/periphBusPkg.sv ====
/*
	core-side bus package
	request strobes from the core and the status word it reads back
*/
package periphBusPkg;

	localparam int BYTE_W = 8;	// core data path width

	// one request per cycle, strobes may overlap
	// 1 + 1 + 1 + 8 = 11 bits
	typedef struct packed {
		logic wr;		// push wrData into tx FIFO
		logic rd;		// pop rx FIFO
		logic statRd;	// status read, clears overrun
		logic [BYTE_W-1:0] wrData;
	} coreReq_t;

	// loaded zero-extended into the accumulator
	typedef struct packed {
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
		logic overrun;	// sticky until status read
	} uartStatus_t;

endpackage

// ==== hw/uartLinePkg.sv ====
/*
	serial line package
	8N1 frame constants and the four-phase state encoding
	shared by the transmitter and the receiver
*/
package uartLinePkg;

	//////////////////////
	// frame format
	//////////////////////
	localparam int OVERSAMPLE = 16;		// ticks per bit
	localparam int DATA_BITS_DEF = 8;	// default payload width
	localparam int SB_TICK_DEF = 16;	// one stop bit at 16x

	//////////////////////
	// engine phases
	//////////////////////
	// same four phases on both sides of the line
	typedef enum logic [1:0] {
		IDLE = 2'b00,	// line high, waiting
		START = 2'b01,	// start bit
		DATA = 2'b10,	// payload bits, LSB first
		STOP = 2'b11	// stop period
	} txState_t;

endpackage
